// ==== src/bank_sched_pkg.sv ====
package bank_sched_pkg;

    // request word, valid bit on top
    localparam int REQ_W      = 16;         // incoming width incl. valid
    localparam int ENTRY_W    = 15;         // stored / issued width

    // field positions, column sits in bits 6..0
    localparam int VALID_POS  = 15;
    localparam int TYPE_POS   = 14;         // read or write
    localparam int ROW_POS    = 10;         // lsb of row field
    localparam int BURST_POS  = 7;          // lsb of burst tag
    localparam int ROW_BITS   = 4;
    localparam int BURST_BITS = 3;

    // queue geometry
    localparam int RD_QUEUES  = 4;          // indices 0..3
    localparam int WR_QUEUES  = 3;          // indices 4..6
    localparam int ALL_QUEUES = RD_QUEUES + WR_QUEUES;
    localparam int RD_DEPTH   = 4;          // entries per read queue
    localparam int WR_DEPTH   = 2;          // entries per write queue

    // write drain watermarks
    localparam int LOW_WM     = 2;          // drain stops here
    localparam int HIGH_WM    = 5;          // drain starts here
    localparam int WR_CNT_W   = 3;          // holds up to 6 writes

    // type codes
    localparam logic REQ_READ  = 1'b0;
    localparam logic REQ_WRITE = 1'b1;

    // class masks over the queue vector
    localparam logic [ALL_QUEUES-1:0] RD_MASK = ALL_QUEUES'((1 << RD_QUEUES) - 1);
    localparam logic [ALL_QUEUES-1:0] WR_MASK = ~RD_MASK;

    // drain FSM encoding
    localparam logic [1:0] ST_IDLE             = 2'd0;
    localparam logic [1:0] ST_READ_BURST       = 2'd1;
    localparam logic [1:0] ST_NEW_WRITE_BURST  = 2'd2;
    localparam logic [1:0] ST_SAME_WRITE_BURST = 2'd3;

    // keeps only the lowest set bit, lowest index wins
    function automatic logic [ALL_QUEUES-1:0] lowest_set(input logic [ALL_QUEUES-1:0] v);
        return v & (~v + 1'b1);
    endfunction

endpackage

// ==== src/row_queue_if.sv ====
interface row_queue_if import bank_sched_pkg::*; ();

    logic                  wr_en;       // push, from steering
    logic [ENTRY_W-1:0]    wr_data;     // request minus valid bit
    logic                  rd_en;       // pop, from drain FSM
    logic [ENTRY_W-1:0]    head;        // oldest entry
    logic                  full;
    logic                  empty;
    logic [ROW_BITS-1:0]   last_row;    // row of newest entry
    logic [BURST_BITS-1:0] head_burst;  // tag of oldest entry

    modport queue (
        input  wr_en, wr_data, rd_en,
        output head, full, empty, last_row, head_burst
    );

    // steering side only needs occupancy and row info
    modport steer (
        output wr_en, wr_data,
        input  full, empty, last_row
    );

    modport drain (
        output rd_en,
        input  head, empty, head_burst
    );

endinterface

// ==== src/row_queue.sv ====
module row_queue import bank_sched_pkg::*; #(
    parameter int DEPTH = RD_DEPTH              // entries held
) (
    input logic        clk,
    input logic        rst_n,
    row_queue_if.queue q
);

    logic [ENTRY_W-1:0]         mem [DEPTH];    // request storage
    logic [$clog2(DEPTH)-1:0]   wr_ptr;         // next free slot
    logic [$clog2(DEPTH)-1:0]   rd_ptr;         // oldest entry
    logic [$clog2(DEPTH+1)-1:0] count;          // occupancy
    logic [ROW_BITS-1:0]        last_row_q;     // row of newest push
    logic                       push;
    logic                       pop;

    // pointer step with wrap at DEPTH
    function automatic logic [$clog2(DEPTH)-1:0] wrap_inc(input logic [$clog2(DEPTH)-1:0] p);
        if (int'(p) == DEPTH - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push = q.wr_en;
    assign pop  = q.rd_en;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= q.wr_data;           // payload only, no reset
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            last_row_q <= '0;
        end else begin
            if (push) begin
                wr_ptr     <= wrap_inc(wr_ptr);
                last_row_q <= q.wr_data[ROW_POS +: ROW_BITS];   // track newest row
            end
            if (pop) begin
                rd_ptr <= wrap_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    assign q.full       = (int'(count) == DEPTH);
    assign q.empty      = (count == '0);
    assign q.head       = mem[rd_ptr];
    assign q.head_burst = mem[rd_ptr][BURST_POS +: BURST_BITS];   // tag of oldest
    assign q.last_row   = last_row_q;

    // steering must never pick a full queue
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        q.wr_en |-> !q.full)
        else $error("row_queue push while full");

    // drain FSM must only pop queues holding data
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        q.rd_en |-> !q.empty)
        else $error("row_queue pop while empty");

endmodule

// ==== src/queue_steer.sv ====
module queue_steer import bank_sched_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [REQ_W-1:0] in,
    output logic             ready,
    row_queue_if.steer       qs [ALL_QUEUES]
);

    logic [ALL_QUEUES-1:0] full_v;      // per queue full flags
    logic [ALL_QUEUES-1:0] empty_v;
    logic [ALL_QUEUES-1:0] row_hit;     // newest row equals request row
    logic [ALL_QUEUES-1:0] cls_mask;    // queues of request class
    logic [ALL_QUEUES-1:0] room_ok;     // in class and not full
    logic [ALL_QUEUES-1:0] hit_ok;
    logic [ALL_QUEUES-1:0] empty_ok;
    logic [ALL_QUEUES-1:0] pick;        // chosen queue as one-hot
    logic [ALL_QUEUES-1:0] wr_en;
    logic                  req_valid;
    logic [ROW_BITS-1:0]   req_row;

    assign req_valid = in[VALID_POS];
    assign req_row   = in[ROW_POS +: ROW_BITS];
    assign cls_mask  = (in[TYPE_POS] == REQ_READ) ? RD_MASK : WR_MASK;

    for (genvar g = 0; g < ALL_QUEUES; g++) begin : g_tap
        assign full_v[g]     = qs[g].full;
        assign empty_v[g]    = qs[g].empty;
        assign row_hit[g]    = (qs[g].last_row == req_row);
        assign qs[g].wr_en   = wr_en[g];
        assign qs[g].wr_data = in[ENTRY_W-1:0];     // broadcast without valid bit
    end

    assign room_ok  = ~full_v & cls_mask;
    assign hit_ok   = row_hit & room_ok;
    assign empty_ok = empty_v & cls_mask;

    // preference order row hit, then empty, then any room
    always_comb begin
        if (|hit_ok) begin
            pick = lowest_set(hit_ok);
        end else if (|empty_ok) begin
            pick = lowest_set(empty_ok);
        end else begin
            pick = lowest_set(room_ok);
        end
    end

    assign wr_en = req_valid ? pick : '0;   // accept in the same cycle

    // upstream holds off while any queue was full
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= ~|full_v;
        end
    end

    // back-pressure must leave room for every request
    a_req_has_room: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> |room_ok)
        else $error("queue_steer request arrives with its class full");

endmodule

// ==== src/drain_fsm.sv ====
module drain_fsm import bank_sched_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               grant,       // gates burst start only
    input  logic               in_write,    // write accepted this cycle
    row_queue_if.drain         qd [ALL_QUEUES],
    output logic [ENTRY_W-1:0] out,
    output logic               out_valid
);

    logic [1:0]            state;
    logic [1:0]            state_nxt;
    logic [ALL_QUEUES-1:0] empty_v;
    logic [ALL_QUEUES-1:0] burst_hit;       // head tag equals burst tag
    logic [ALL_QUEUES-1:0] rd_en;
    logic [ALL_QUEUES-1:0] rd_ready;        // non-empty read queues
    logic [ALL_QUEUES-1:0] wr_ready;        // non-empty write queues
    logic [ALL_QUEUES-1:0] rd_hits;
    logic [ALL_QUEUES-1:0] wr_hits;
    logic [ENTRY_W-1:0]    head_v [ALL_QUEUES];
    logic [ENTRY_W-1:0]    sel_head;        // entry being popped
    logic [BURST_BITS-1:0] tag_q;           // tag of previous issue
    logic                  tag_vld;
    logic                  tag_clr;
    logic [WR_CNT_W-1:0]   wr_cnt;          // writes held in queues
    logic                  wr_issue;
    logic                  above_high;
    logic                  above_low;

    for (genvar g = 0; g < ALL_QUEUES; g++) begin : g_tap
        assign empty_v[g]   = qd[g].empty;
        assign head_v[g]    = qd[g].head;
        assign burst_hit[g] = tag_vld && !qd[g].empty && (qd[g].head_burst == tag_q);
        assign qd[g].rd_en  = rd_en[g];
    end

    assign rd_ready   = ~empty_v & RD_MASK;
    assign wr_ready   = ~empty_v & WR_MASK;
    assign rd_hits    = burst_hit & RD_MASK;
    assign wr_hits    = burst_hit & WR_MASK;
    assign above_high = (wr_cnt >= WR_CNT_W'(HIGH_WM));
    assign above_low  = (wr_cnt > WR_CNT_W'(LOW_WM));
    assign wr_issue   = |(rd_en & WR_MASK);

    // next state and pop select
    always_comb begin
        state_nxt = state;
        rd_en     = '0;
        tag_clr   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (grant && above_high && |wr_ready) begin
                    rd_en     = lowest_set(wr_ready);    // writes take over
                    state_nxt = ST_NEW_WRITE_BURST;
                end else if (grant && !above_high && |rd_ready) begin
                    rd_en     = lowest_set(rd_ready);    // read first
                    state_nxt = ST_READ_BURST;
                end
            end
            ST_READ_BURST: begin
                if (|rd_hits) begin
                    rd_en = lowest_set(rd_hits);         // same tag continues
                end else begin
                    tag_clr   = 1'b1;
                    state_nxt = ST_IDLE;
                end
            end
            ST_NEW_WRITE_BURST, ST_SAME_WRITE_BURST: begin
                if (|wr_hits) begin
                    rd_en     = lowest_set(wr_hits);
                    state_nxt = ST_SAME_WRITE_BURST;
                end else if (above_low && |wr_ready) begin
                    rd_en     = lowest_set(wr_ready);    // keep draining to low mark
                    state_nxt = ST_NEW_WRITE_BURST;
                end else begin
                    tag_clr   = 1'b1;
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // OR mux over the one-hot rd_en
    always_comb begin
        sel_head = '0;
        for (int i = 0; i < ALL_QUEUES; i++) begin
            if (rd_en[i]) begin
                sel_head = sel_head | head_v[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || tag_clr) begin
            tag_q   <= '0;
            tag_vld <= 1'b0;
        end else if (|rd_en) begin
            tag_q   <= sel_head[BURST_POS +: BURST_BITS];   // remember issued tag
            tag_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= |rd_en;                // one cycle after pop
            if (|rd_en) begin
                out <= sel_head;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else begin
            case ({in_write, wr_issue})
                2'b10:   wr_cnt <= wr_cnt + 1'b1;
                2'b01:   wr_cnt <= wr_cnt - 1'b1;
                default: wr_cnt <= wr_cnt;      // in and out cancel
            endcase
        end
    end

    // count must agree with what the write queues hold
    a_cnt_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_issue && !in_write) |-> (wr_cnt != '0))
        else $error("drain_fsm write count underflow");

    a_cnt_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (in_write && !wr_issue) |-> (int'(wr_cnt) < WR_QUEUES * WR_DEPTH))
        else $error("drain_fsm write count overflow");

endmodule

// ==== src/bank_scheduler.sv ====
module bank_scheduler import bank_sched_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [REQ_W-1:0]   in,          // request with valid on top
    input  logic               grant,       // permission to start a burst
    output logic               ready,       // upstream may present
    output logic [ENTRY_W-1:0] out,         // issued request
    output logic               out_valid
);

    logic in_write;                         // write accepted this cycle

    // 0..3 read queues, 4..6 write queues
    row_queue_if rq [ALL_QUEUES] ();

    assign in_write = in[VALID_POS] && (in[TYPE_POS] == REQ_WRITE);

    for (genvar g = 0; g < RD_QUEUES; g++) begin : g_rd_q
        row_queue #(
            .DEPTH (RD_DEPTH)
        ) u_rd_queue (
            .clk   (clk),
            .rst_n (rst_n),
            .q     (rq[g])
        );
    end

    for (genvar g = 0; g < WR_QUEUES; g++) begin : g_wr_q
        row_queue #(
            .DEPTH (WR_DEPTH)               // shallower write side
        ) u_wr_queue (
            .clk   (clk),
            .rst_n (rst_n),
            .q     (rq[RD_QUEUES + g])
        );
    end

    // places each request by row hit
    queue_steer u_steer (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (in),
        .ready (ready),
        .qs    (rq)
    );

    // burst and watermark control
    drain_fsm u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .grant     (grant),
        .in_write  (in_write),
        .qd        (rq),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

// ==== verification/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);      // 8 cycles in reset
        rst_n <= 1'b1;
    end
endmodule

// ==== verification/tb_bank_scheduler.sv ====
module tb_bank_scheduler import bank_sched_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_STEPS   = 40;                  // random traffic steps
    localparam int MAX_REQ   = 8 + 16 + N_STEPS + 15;
    localparam int WATCH_CYC = MAX_REQ * 40 + 8;

    logic               clk, rst_n, grant, ready, out_valid;
    logic [REQ_W-1:0]   in;
    logic [ENTRY_W-1:0] out;
    logic [ENTRY_W-1:0] pend[$];                    // accepted but not yet issued
    logic [ENTRY_W-1:0] issue_log[$];
    logic [ENTRY_W-1:0] prev_out;
    logic [15:0]        lfsr = 16'd98;
    logic [3:0]         wr_row = 4'd1;              // fresh write rows skip 0
    logic has_prev = 1'b0, post_rst = 1'b0, in_w_prev = 1'b0, rand_grant = 1'b0;
    int   errors = 0, issued_cnt = 0, cyc = 0, wr_cnt_ref = 0, idx;

    clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    bank_scheduler UUT (.clk(clk), .rst_n(rst_n), .in(in), .grant(grant),
                        .ready(ready), .out(out), .out_valid(out_valid));

    function automatic logic [REQ_W-1:0] make_req(input logic wr, input logic [3:0] row,
                                                  input logic [2:0] tag, input logic [6:0] col);
        return {1'b1, wr, row, tag, col};
    endfunction

    function automatic int find_pending(input logic [ENTRY_W-1:0] e);
        foreach (pend[i]) begin
            if (pend[i] == e) return i;
        end
        return -1;
    endfunction

    // read-first and watermark rules with cnt from the pop cycle
    function automatic bit issue_legal(input logic [ENTRY_W-1:0] e, input int cnt,
                                       input bit has_p, input logic [ENTRY_W-1:0] p);
        if (has_p && p[TYPE_POS] == e[TYPE_POS]
                && p[BURST_POS +: BURST_BITS] == e[BURST_POS +: BURST_BITS]) begin
            return 1'b1;                            // same burst continues
        end
        if (e[TYPE_POS] == REQ_READ) return cnt < HIGH_WM;
        return cnt > LOW_WM;
    endfunction

    // taps 16,14,13,11
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic step_grant();
        logic [15:0] b;
        if (rand_grant) begin
            b = take_bits(2);
            grant <= |b[1:0];                       // high 3 of 4 cycles
        end
    endtask

    task automatic send(input logic [REQ_W-1:0] r);
        do begin
            @(posedge clk);
            step_grant();
            if (ready !== 1'b1) in <= '0;
        end while (ready !== 1'b1);
        in <= r;                                    // held for one cycle
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk);
            in <= '0;
            step_grant();
            @(negedge clk);
        end while (pend.size() != 0);
    endtask

    // five writes on fresh rows and one tag, so a drain empties them all
    task automatic send_write_group();
        logic [15:0] tag, col;
        wait_drained();
        tag = take_bits(3);
        for (int i = 0; i < 5; i++) begin
            col = take_bits(7);
            send(make_req(REQ_WRITE, wr_row, tag[2:0], col[6:0]));
            wr_row = wr_row + 4'd1;
        end
    endtask

    always @(posedge clk) begin : compare
        if (cyc >= 1 && (!rst_n || post_rst)) begin
            assert (out_valid === 1'b0 && ready === 1'b0 && out === '0) else begin
                errors++;
                $display("Mismatch: reset state out_valid=%h ready=%h out=%h",
                         out_valid, ready, out);
            end
        end
        cyc++;
        post_rst = !rst_n;                          // also check first cycle after
        if (rst_n && out_valid === 1'b1) begin
            idx = find_pending(out);
            assert (idx >= 0) else begin
                errors++;
                $display("Mismatch: out=%h matches no pending request", out);
            end
            if (idx >= 0) pend.delete(idx);
            assert (issue_legal(out, wr_cnt_ref, has_prev, prev_out)) else begin
                errors++;
                $display("issue %h breaks burst or watermark order at write count %0d",
                         out, wr_cnt_ref);
            end
            prev_out = out;
            has_prev = 1'b1;
            issued_cnt++;
            issue_log.push_back(out);
        end
        // count seen by the FSM one cycle earlier
        wr_cnt_ref = wr_cnt_ref + int'(in_w_prev)
                   - int'(rst_n && out_valid === 1'b1 && out[TYPE_POS] == REQ_WRITE);
        in_w_prev  = rst_n && in[VALID_POS] && in[TYPE_POS] == REQ_WRITE;
        if (rst_n && in[VALID_POS]) pend.push_back(in[ENTRY_W-1:0]);
    end

    initial begin : watchdog
        #(WATCH_CYC * 100);
        $display("watchdog expired before all requests were issued, errors: %0d", errors + 1);
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        logic [15:0] pick, row, tag, col;
        int first, last, n5, sent, base;
        bit saw_low;
        logic [2:0] tags [8] = '{3'd1, 3'd5, 3'd5, 3'd2, 3'd5, 3'd3, 3'd4, 3'd6};
        in    = '0;
        grant = 1'b0;
        // preload with grant low and tag 5 spread over queues
        for (int i = 0; i < 8; i++) send(make_req(REQ_READ, 4'(i + 1), tags[i], 7'(i)));
        repeat (40) begin
            @(posedge clk);
            in <= '0;
        end
        @(negedge clk);
        assert (issued_cnt == 0) else begin
            errors++;
            $display("a request was issued while grant was held low");
        end
        @(posedge clk);
        grant <= 1'b1;
        wait_drained();
        first = -1;
        last  = -1;
        n5    = 0;
        foreach (issue_log[i]) begin
            if (issue_log[i][BURST_POS +: BURST_BITS] == 3'd5) begin
                if (first < 0) first = i;
                last = i;
                n5++;
            end
        end
        assert (n5 == 3 && last - first == 2) else begin
            errors++;
            $display("reads sharing burst tag 5 were not issued back to back");
        end
        // flow control on distinct rows with grant low
        @(posedge clk);
        grant <= 1'b0;
        @(negedge clk);
        base    = issued_cnt;
        sent    = 0;
        saw_low = 1'b0;
        while (sent < 16 && !saw_low) begin
            @(posedge clk);
            if (ready) begin
                in <= make_req(REQ_READ, 4'(sent), 3'(sent), 7'(sent));
                sent++;
            end else begin
                in <= '0;
                saw_low = 1'b1;
            end
        end
        repeat (4) begin
            @(posedge clk);
            in <= '0;
            if (!ready) saw_low = 1'b1;
        end
        assert (saw_low) else begin
            errors++;
            $display("ready stayed high after %0d reads with grant low", sent);
        end
        @(posedge clk);
        grant <= 1'b1;
        wait_drained();
        assert (issued_cnt - base == sent) else begin
            errors++;
            $display("Mismatch: issued count %h, accepted %h", issued_cnt - base, sent);
        end
        // random mixed traffic with grant toggling
        rand_grant = 1'b1;
        for (int s = 0; s < N_STEPS; s++) begin
            pick = take_bits(3);
            if (pick[2:0] == 3'd0 && wr_row != 4'd0) begin
                send_write_group();
            end else begin
                row = take_bits(4);
                tag = take_bits(3);
                col = take_bits(7);
                send(make_req(REQ_READ, row[3:0], tag[2:0], col[6:0]));
            end
        end
        while (wr_row != 4'd0) send_write_group();  // use all fresh write rows
        wait_drained();
        repeat (4) @(posedge clk);                  // idle tail catches stray issues
        $display("errors: %0d, requests issued: %0d", errors, issued_cnt);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

// ==== sources.f ====
src/bank_sched_pkg.sv
src/row_queue_if.sv
src/row_queue.sv
src/queue_steer.sv
src/drain_fsm.sv
src/bank_scheduler.sv
verification/clk_gen.sv
verification/tb_bank_scheduler.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_bank_scheduler
FILELIST = sources.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
